/* wb_bus_pkg.sv */
package wb_bus_pkg;

  localparam int WB_AW = 16;
  localparam int WB_DW = 16;

  typedef logic [WB_AW-1:0] wb_adr_t;
  typedef logic [WB_DW-1:0] wb_dat_t;

  localparam int REG_RANGE_TOP = 256; // Everything below this decodes to the register bank
  localparam int REG_COUNT     = 16;  // Number of implemented registers in that range

endpackage

/* wb_arb_pkg.sv */
package wb_arb_pkg;

  // Arbiter phases for one bus cycle
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    GRANT = 2'd1,
    WAIT  = 2'd2
  } arb_state_t;

  // Index of a bus master, sized for up to four of them
  typedef logic [1:0] mst_id_t;

endpackage

/* wb_arb_fsm.sv */
module wb_arb_fsm #(
  parameter int NUM_MASTERS = 4
) (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic [NUM_MASTERS-1:0] req_i,
  input  logic [NUM_MASTERS-1:0] mask_i,
  input  logic                   bus_ack_i,
  input  logic                   bus_err_i,
  input  logic                   timeout_i,
  output wb_arb_pkg::mst_id_t    grant_id_o,
  output logic                   cyc_active_o,
  output logic                   timer_clr_o
);
  import wb_arb_pkg::*;

  arb_state_t             state_q;
  logic [NUM_MASTERS-1:0] pending_q;
  logic [NUM_MASTERS-1:0] pending_nxt;
  logic                   cycle_done;

  // Last set bit wins, so the highest index has priority
  function automatic mst_id_t highest_pending(input logic [NUM_MASTERS-1:0] pend);
    mst_id_t id;
    id = '0;
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (pend[i]) begin
        id = mst_id_t'(i);
      end
    end
    return id;
  endfunction

  assign cycle_done = cyc_active_o & (bus_ack_i | bus_err_i | timeout_i);

  // The timer restarts on the same edge that opens the cycle
  assign timer_clr_o = (state_q == IDLE) && (|pending_q);

  always_comb begin
    pending_nxt = pending_q | (req_i & mask_i);
    if (cycle_done) begin
      pending_nxt[grant_id_o] = 1'b0; // Served master drops out even though stb is still up
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q      <= IDLE;
      pending_q    <= '0;
      grant_id_o   <= '0;
      cyc_active_o <= 1'b0;
    end else begin
      pending_q <= pending_nxt;
      case (state_q)
        IDLE: begin
          if (|pending_q) begin
            state_q      <= GRANT;
            grant_id_o   <= highest_pending(pending_q);
            cyc_active_o <= 1'b1;
          end
        end
        GRANT: begin
          if (cycle_done) begin
            state_q      <= IDLE;
            cyc_active_o <= 1'b0;
          end else begin
            state_q <= WAIT;
          end
        end
        WAIT: begin
          if (cycle_done) begin
            state_q      <= IDLE; // Bus sits idle for a cycle before the next grant
            cyc_active_o <= 1'b0;
          end
        end
        default: begin
          state_q      <= IDLE;
          cyc_active_o <= 1'b0;
        end
      endcase
    end
  end

endmodule

/* wb_resp_timer.sv */
module wb_resp_timer #(
  parameter int TIMEOUT_CYCLES = 16
) (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic clr_i,
  input  logic run_i,
  output logic timeout_o
);

  localparam int CW = (TIMEOUT_CYCLES > 1) ? $clog2(TIMEOUT_CYCLES) : 1;

  logic [CW-1:0] count_q;
  logic          done_q;
  logic          at_limit;

  assign at_limit  = (count_q == CW'(TIMEOUT_CYCLES - 1));
  assign timeout_o = run_i & ~done_q & at_limit;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      count_q <= '0;
      done_q  <= 1'b0;
    end else if (clr_i) begin
      count_q <= '0;
      done_q  <= 1'b0;
    end else if (run_i && !done_q) begin
      if (at_limit) begin
        done_q <= 1'b1; // Fire once, then hold until the next clear
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

/* wb_master_mux.sv */
module wb_master_mux #(
  parameter int NUM_MASTERS = 4
) (
  input  wb_arb_pkg::mst_id_t                      grant_id_i,
  input  logic                                     cyc_active_i,
  input  logic [NUM_MASTERS-1:0]                   wbm_we_i,
  input  logic [wb_bus_pkg::WB_AW*NUM_MASTERS-1:0] wbm_adr_i,
  input  logic [wb_bus_pkg::WB_DW*NUM_MASTERS-1:0] wbm_dat_i,
  input  logic                                     s_ack_i,
  input  logic                                     s_err_i,
  input  wb_bus_pkg::wb_dat_t                      s_rdat_i,
  input  logic                                     timeout_i,
  output logic                                     s_cyc_o,
  output logic                                     s_stb_o,
  output logic                                     s_we_o,
  output wb_bus_pkg::wb_adr_t                      s_adr_o,
  output wb_bus_pkg::wb_dat_t                      s_wdat_o,
  output wb_bus_pkg::wb_dat_t                      wbm_dat_o,
  output logic [NUM_MASTERS-1:0]                   wbm_ack_o,
  output logic [NUM_MASTERS-1:0]                   wbm_err_o,
  output logic                                     bus_ack_o,
  output logic                                     bus_err_o
);
  import wb_bus_pkg::*;

  logic in_range;
  logic resp_err;

  assign s_adr_o  = wbm_adr_i[grant_id_i*WB_AW +: WB_AW];
  assign s_wdat_o = wbm_dat_i[grant_id_i*WB_DW +: WB_DW];
  assign s_we_o   = wbm_we_i[grant_id_i];

  // Addresses past the bank select nothing and are left to the timer
  assign in_range = (s_adr_o < REG_RANGE_TOP);
  assign s_cyc_o  = cyc_active_i & in_range;
  assign s_stb_o  = cyc_active_i & in_range;

  assign resp_err  = s_err_i | (timeout_i & ~s_ack_i); // A late ack still beats the timer
  assign bus_ack_o = s_ack_i;
  assign bus_err_o = resp_err;
  assign wbm_dat_o = s_rdat_i;

  always_comb begin
    wbm_ack_o = '0;
    wbm_err_o = '0;
    if (cyc_active_i) begin
      wbm_ack_o[grant_id_i] = s_ack_i;
      wbm_err_o[grant_id_i] = resp_err;
    end
  end

endmodule

/* wb_reg_bank.sv */
module wb_reg_bank #(
  parameter int WAIT_STATES = 2
) (
  input  logic                wb_clk_i,
  input  logic                wb_rst_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  wb_bus_pkg::wb_adr_t adr_i,
  input  wb_bus_pkg::wb_dat_t dat_i,
  output wb_bus_pkg::wb_dat_t dat_o,
  output logic                ack_o,
  output logic                err_o
);
  import wb_bus_pkg::*;

  localparam int IW = $clog2(REG_COUNT);
  localparam int CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  wb_dat_t       regs_q [REG_COUNT];
  logic [CW-1:0] wait_q;
  logic          req;
  logic          ready;
  logic          hit;
  logic [IW-1:0] idx;

  assign req   = cyc_i & stb_i;
  assign ready = req && (wait_q == CW'(WAIT_STATES));
  assign hit   = (adr_i < REG_COUNT);
  assign idx   = adr_i[IW-1:0];

  // Response is one cycle wide and only while stb is up
  assign ack_o = ready & hit;
  assign err_o = ready & ~hit;
  assign dat_o = regs_q[idx];

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wait_q <= '0;
    end else if (req && !ready) begin
      wait_q <= wait_q + 1'b1;
    end else begin
      wait_q <= '0; // Rearm for the next cycle
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (ack_o && we_i) begin
      regs_q[idx] <= dat_i;
    end
  end

endmodule

/* wb_arb_top.sv */
module wb_arb_top #(
  parameter int NUM_MASTERS    = 4,
  parameter int TIMEOUT_CYCLES = 16,
  parameter int WAIT_STATES    = 2
) (
  input  logic                                     wb_clk_i,
  input  logic                                     wb_rst_i,
  input  logic [NUM_MASTERS-1:0]                   wbm_cyc_i,
  input  logic [NUM_MASTERS-1:0]                   wbm_stb_i,
  input  logic [NUM_MASTERS-1:0]                   wbm_we_i,
  input  logic [wb_bus_pkg::WB_AW*NUM_MASTERS-1:0] wbm_adr_i,
  input  logic [wb_bus_pkg::WB_DW*NUM_MASTERS-1:0] wbm_dat_i,
  input  logic [NUM_MASTERS-1:0]                   wbm_mask_i,
  output wb_bus_pkg::wb_dat_t                      wbm_dat_o,
  output logic [NUM_MASTERS-1:0]                   wbm_ack_o,
  output logic [NUM_MASTERS-1:0]                   wbm_err_o,
  output wb_arb_pkg::mst_id_t                      wbm_id_o
);
  import wb_bus_pkg::*;
  import wb_arb_pkg::*;

  mst_id_t grant_id;
  logic    cyc_active;
  logic    timer_clr;
  logic    timeout;
  logic    bus_ack;
  logic    bus_err;
  logic    s_cyc;
  logic    s_stb;
  logic    s_we;
  wb_adr_t s_adr;
  wb_dat_t s_wdat;
  wb_dat_t s_rdat;
  logic    s_ack;
  logic    s_err;

  assign wbm_id_o = grant_id;

  wb_arb_fsm #(
    .NUM_MASTERS(NUM_MASTERS)
  ) u_fsm (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .req_i       (wbm_cyc_i & wbm_stb_i),
    .mask_i      (wbm_mask_i),
    .bus_ack_i   (bus_ack),
    .bus_err_i   (bus_err),
    .timeout_i   (timeout),
    .grant_id_o  (grant_id),
    .cyc_active_o(cyc_active),
    .timer_clr_o (timer_clr)
  );

  wb_resp_timer #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) u_timer (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .clr_i    (timer_clr),
    .run_i    (cyc_active),
    .timeout_o(timeout)
  );

  wb_master_mux #(
    .NUM_MASTERS(NUM_MASTERS)
  ) u_mux (
    .grant_id_i  (grant_id),
    .cyc_active_i(cyc_active),
    .wbm_we_i    (wbm_we_i),
    .wbm_adr_i   (wbm_adr_i),
    .wbm_dat_i   (wbm_dat_i),
    .s_ack_i     (s_ack),
    .s_err_i     (s_err),
    .s_rdat_i    (s_rdat),
    .timeout_i   (timeout),
    .s_cyc_o     (s_cyc),
    .s_stb_o     (s_stb),
    .s_we_o      (s_we),
    .s_adr_o     (s_adr),
    .s_wdat_o    (s_wdat),
    .wbm_dat_o   (wbm_dat_o),
    .wbm_ack_o   (wbm_ack_o),
    .wbm_err_o   (wbm_err_o),
    .bus_ack_o   (bus_ack),
    .bus_err_o   (bus_err)
  );

  wb_reg_bank #(
    .WAIT_STATES(WAIT_STATES)
  ) u_regs (
    .wb_clk_i(wb_clk_i),
    .wb_rst_i(wb_rst_i),
    .cyc_i   (s_cyc),
    .stb_i   (s_stb),
    .we_i    (s_we),
    .adr_i   (s_adr),
    .dat_i   (s_wdat),
    .dat_o   (s_rdat),
    .ack_o   (s_ack),
    .err_o   (s_err)
  );

endmodule

/* tb_wb_arb_top.sv */
module tb_wb_arb_top;
  timeunit 1ns;
  timeprecision 1ps;

  import wb_bus_pkg::*;
  import wb_arb_pkg::*;

  localparam int NUM_MASTERS    = 4;
  localparam int TIMEOUT_CYCLES = 16;
  localparam int WAIT_STATES    = 2;
  localparam int RESP_LIMIT     = TIMEOUT_CYCLES + 4;
  localparam int CYCLE_LIMIT    = 2000; // Several times the length of all tests
  localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

  logic                           wb_clk_i   = 1'b0;
  logic                           wb_rst_i   = 1'b1;
  logic [NUM_MASTERS-1:0]         wbm_cyc_i  = '0;
  logic [NUM_MASTERS-1:0]         wbm_stb_i  = '0;
  logic [NUM_MASTERS-1:0]         wbm_we_i   = '0;
  logic [WB_AW*NUM_MASTERS-1:0]   wbm_adr_i  = '0;
  logic [WB_DW*NUM_MASTERS-1:0]   wbm_dat_i  = '0;
  logic [NUM_MASTERS-1:0]         wbm_mask_i = '1;
  wb_dat_t                        wbm_dat_o;
  logic [NUM_MASTERS-1:0]         wbm_ack_o;
  logic [NUM_MASTERS-1:0]         wbm_err_o;
  mst_id_t                        wbm_id_o;

  logic [31:0] lfsr      = 32'h2141_c008;
  int unsigned cycle_cnt = 0;
  wb_dat_t     exp_regs [REG_COUNT]; // Expected contents of the register bank
  mst_id_t     done_order [$];

  wb_arb_top #(
    .NUM_MASTERS   (NUM_MASTERS),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
    .WAIT_STATES   (WAIT_STATES)
  ) u_wb_arb_top (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbm_cyc_i (wbm_cyc_i),
    .wbm_stb_i (wbm_stb_i),
    .wbm_we_i  (wbm_we_i),
    .wbm_adr_i (wbm_adr_i),
    .wbm_dat_i (wbm_dat_i),
    .wbm_mask_i(wbm_mask_i),
    .wbm_dat_o (wbm_dat_o),
    .wbm_ack_o (wbm_ack_o),
    .wbm_err_o (wbm_err_o),
    .wbm_id_o  (wbm_id_o)
  );

  always #20 wb_clk_i = ~wb_clk_i;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_dat(input string name, input wb_dat_t got, input wb_dat_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_id(input string name, input mst_id_t got, input mst_id_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // One LFSR step per bit taken with the LSB first
  function automatic wb_dat_t next_rand_word();
    wb_dat_t w;
    logic    out_bit;
    for (int i = 0; i < WB_DW; i++) begin
      out_bit = lfsr[0];
      lfsr    = {1'b0, lfsr[31:1]} ^ (out_bit ? LFSR_POLY : 32'h0);
      w[i]    = out_bit;
    end
    return w;
  endfunction

  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      stop_on_error($sformatf("Simulation exceeded its cycle limit of %0d cycles", CYCLE_LIMIT));
    end
  end

  // Only the granted master may ever see ack or err
  always @(negedge wb_clk_i) begin
    if (!wb_rst_i) begin
      for (int i = 0; i < NUM_MASTERS; i++) begin
        if (mst_id_t'(i) != wbm_id_o) begin
          check_flag($sformatf("wbm_ack_o[%0d]", i), wbm_ack_o[i], 1'b0);
          check_flag($sformatf("wbm_err_o[%0d]", i), wbm_err_o[i], 1'b0);
        end
      end
    end
  end

  task automatic start_req(input mst_id_t id, input logic we, input wb_adr_t adr,
                           input wb_dat_t dat);
    @(posedge wb_clk_i);
    wbm_cyc_i[id]                <= 1'b1;
    wbm_stb_i[id]                <= 1'b1;
    wbm_we_i[id]                 <= we;
    wbm_adr_i[id*WB_AW +: WB_AW] <= adr;
    wbm_dat_i[id*WB_DW +: WB_DW] <= dat;
  endtask

  // Master holds its request until ack or err, then drops it on the next edge
  task automatic wait_resp(input mst_id_t id, output logic ack, output logic err,
                           output wb_dat_t rdat);
    int n;
    n    = 0;
    ack  = 1'b0;
    err  = 1'b0;
    rdat = '0;
    while (!ack && !err) begin
      @(negedge wb_clk_i);
      ack  = wbm_ack_o[id];
      err  = wbm_err_o[id];
      rdat = wbm_dat_o;
      n++;
      if (!ack && !err && n > RESP_LIMIT) begin
        stop_on_error($sformatf("Master %0d got no response within %0d cycles", id, RESP_LIMIT));
      end
    end
    check_id("wbm_id_o", wbm_id_o, id);
    done_order.push_back(id);
    @(posedge wb_clk_i);
    wbm_cyc_i[id] <= 1'b0;
    wbm_stb_i[id] <= 1'b0;
  endtask

  task automatic finish_access(input mst_id_t id, input logic we, input wb_adr_t adr,
                               input wb_dat_t dat);
    logic    ack;
    logic    err;
    wb_dat_t rdat;
    logic    mapped;
    mapped = (adr < REG_COUNT); // Anything else ends in err from the bank or the timer
    wait_resp(id, ack, err, rdat);
    check_flag($sformatf("wbm_ack_o[%0d]", id), ack, mapped);
    check_flag($sformatf("wbm_err_o[%0d]", id), err, !mapped);
    if (mapped && we) begin
      exp_regs[adr] = dat;
    end else if (mapped) begin
      check_dat("wbm_dat_o", rdat, exp_regs[adr]);
    end
  endtask

  task automatic access(input mst_id_t id, input logic we, input wb_adr_t adr,
                        input wb_dat_t dat);
    start_req(id, we, adr, dat);
    finish_access(id, we, adr, dat);
  endtask

  task automatic write_read_all();
    for (int r = 0; r < REG_COUNT; r++) begin
      access(2'd0, 1'b1, wb_adr_t'(r), next_rand_word());
    end
    for (int r = 0; r < REG_COUNT; r++) begin
      access(2'd0, 1'b0, wb_adr_t'(r), '0);
    end
  endtask

  task automatic priority_pair();
    done_order.delete();
    fork
      access(2'd0, 1'b0, 16'd1, '0);
      access(2'd2, 1'b1, 16'd2, next_rand_word());
    join
    check_id("first served master", done_order[0], 2'd2);
    check_id("second served master", done_order[1], 2'd0);
  endtask

  task automatic masked_master();
    wb_dat_t d;
    d = next_rand_word();
    @(posedge wb_clk_i);
    wbm_mask_i[1] <= 1'b0;
    start_req(2'd1, 1'b1, 16'd5, d);
    fork
      repeat (40) begin
        @(negedge wb_clk_i);
        check_flag("wbm_ack_o[1]", wbm_ack_o[1], 1'b0);
        check_flag("wbm_err_o[1]", wbm_err_o[1], 1'b0);
      end
      begin
        repeat (4) @(posedge wb_clk_i);
        access(2'd3, 1'b1, 16'd6, next_rand_word());
      end
    join
    @(posedge wb_clk_i);
    wbm_mask_i[1] <= 1'b1;
    finish_access(2'd1, 1'b1, 16'd5, d);
    access(2'd0, 1'b0, 16'd5, '0);
  endtask

  task automatic bank_error();
    access(2'd3, 1'b1, 16'd16, next_rand_word()); // Shares index bits with register 0
    access(2'd3, 1'b0, 16'd0, '0);
  endtask

  task automatic unmapped_timeout();
    access(2'd2, 1'b0, 16'd300, '0);
    access(2'd1, 1'b0, 16'd3, '0);
  endtask

  initial begin
    for (int r = 0; r < REG_COUNT; r++) begin
      exp_regs[r] = '0;
    end
    repeat (3) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;
    @(negedge wb_clk_i);
    check_flag("wbm_ack_o", |wbm_ack_o, 1'b0);
    check_flag("wbm_err_o", |wbm_err_o, 1'b0);
    check_id("wbm_id_o", wbm_id_o, 2'd0);
    write_read_all();
    priority_pair();
    masked_master();
    bank_error();
    unmapped_timeout();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* build.f */
wb_bus_pkg.sv
wb_arb_pkg.sv
wb_arb_fsm.sv
wb_resp_timer.sv
wb_master_mux.sv
wb_reg_bank.sv
wb_arb_top.sv
tb_wb_arb_top.sv
